// ==== hw/mmu_cfg_pkg.sv ====
package mmu_cfg_pkg;

// ============================================================================
// Address fields
// ============================================================================
localparam int VADR_W      = 32;	// Virtual address width
localparam int PADR_W      = 32;	// Physical address width
localparam int PAGE_BITS   = 12;	// 4 KB page offset
localparam int VPN1_LSB    = 22;	// Level-1 index is vadr[31:22]
localparam int VPN0_LSB    = 12;	// Level-0 index is vadr[21:12]
localparam int PPN_W       = 20;	// Physical page number width
localparam int PTE_BYTES   = 4;	// One PTE word per table slot

// ============================================================================
// TLB geometry
// ============================================================================
localparam int TLB_IDX_BITS = 4;
localparam int TLB_ENTRIES  = 16;
// Index sits at vadr[15:12], tag is everything above it
localparam int TLB_TAG_LSB  = 16;

// ============================================================================
// APB register map
// ============================================================================
localparam int APB_ADDR_W = 8;

localparam logic [APB_ADDR_W-1:0] REG_PTBR      = 8'h00;	// Table base, write flushes
localparam logic [APB_ADDR_W-1:0] REG_CTRL      = 8'h04;	// Bit 0 paging enable
localparam logic [APB_ADDR_W-1:0] REG_FAULT_ADR = 8'h08;	// Read only
localparam logic [APB_ADDR_W-1:0] REG_STATUS    = 8'h0C;	// Bit 0 fault pending, W1C

endpackage

// ==== hw/mmu_types_pkg.sv ====
package mmu_types_pkg;

// ============================================================================
// Bus ports
// ============================================================================
typedef struct packed {
	logic                                psel;
	logic                                penable;
	logic                                pwrite;
	logic [mmu_cfg_pkg::APB_ADDR_W-1:0]  paddr;
	logic [31:0]                         pwdata;
} apb_req_t;

typedef struct packed {
	logic        pready;
	logic        pslverr;
	logic [31:0] prdata;
} apb_rsp_t;

// Translation request and response
typedef struct packed {
	logic                            valid;
	logic [mmu_cfg_pkg::VADR_W-1:0]  vadr;
} xlat_req_t;

typedef struct packed {
	logic                            valid;
	logic                            fault;
	logic [mmu_cfg_pkg::PADR_W-1:0]  padr;
} xlat_rsp_t;

// Page table read port
typedef struct packed {
	logic                            valid;
	logic [mmu_cfg_pkg::PADR_W-1:0]  adr;
} mem_req_t;

typedef struct packed {
	logic        ack;
	logic [31:0] data;	// One PTE word
} mem_rsp_t;

// ============================================================================
// Internal links
// ============================================================================
typedef struct packed {
	logic                            valid;
	logic [mmu_cfg_pkg::VADR_W-1:0]  vadr;
} tlb_miss_t;

typedef struct packed {
	logic                            valid;
	logic                            fault;
	logic [mmu_cfg_pkg::VADR_W-1:0]  vadr;
	logic [mmu_cfg_pkg::PPN_W-1:0]   ppn;
} tlb_fill_t;

typedef struct packed {
	logic                            paging_en;
	logic [mmu_cfg_pkg::PPN_W-1:0]   ptbr_ppn;
	logic                            flush;	// One cycle, on PTBR write
} csr_ctl_t;

// ============================================================================
// Page table entry, one word seen two ways
// ============================================================================
typedef struct packed {
	logic                                           v;
	logic                                           s;	// Superpage at level 1
	logic [31-2-mmu_cfg_pkg::PPN_W:0]               rsvd;
	logic [mmu_cfg_pkg::PPN_W-1:0]                  ppn;
} pte_leaf_t;

typedef struct packed {
	logic                                           v;
	logic                                           s;	// Zero for a pointer
	logic [31-2-mmu_cfg_pkg::PPN_W:0]               rsvd;
	logic [mmu_cfg_pkg::PPN_W-1:0]                  tppn;	// Level-0 table page
} pte_ptr_t;

typedef union packed {
	pte_leaf_t leaf;
	pte_ptr_t  ptr;
} pte_u;

endpackage

// ==== hw/mmu_csr.sv ====
module mmu_csr (
	input  logic                      clk,
	input  logic                      rst,
	input  mmu_types_pkg::apb_req_t   apb_i,
	input  mmu_types_pkg::tlb_fill_t  fill_i,
	output mmu_types_pkg::apb_rsp_t   apb_o,
	output mmu_types_pkg::csr_ctl_t   ctl_o,
	output logic                      irq_o
);

logic                               access;	// APB access phase
logic                               reg_hit;	// Offset is in the map
logic                               wr_en;
logic                               wr_ptbr;
logic                               wr_ctrl;
logic                               sts_clr;
logic                               hw_fault;
logic [31:0]                        rd_data;

logic [mmu_cfg_pkg::PPN_W-1:0]      ptbr_ppn_q;
logic                               paging_en_q;
logic                               fault_pend_q;
logic [mmu_cfg_pkg::VADR_W-1:0]     fault_adr_q;

assign access   = apb_i.psel & apb_i.penable;
assign wr_en    = access & apb_i.pwrite & reg_hit;
assign wr_ptbr  = wr_en & (apb_i.paddr == mmu_cfg_pkg::REG_PTBR);
assign wr_ctrl  = wr_en & (apb_i.paddr == mmu_cfg_pkg::REG_CTRL);
assign sts_clr  = wr_en & (apb_i.paddr == mmu_cfg_pkg::REG_STATUS) & apb_i.pwdata[0];
assign hw_fault = fill_i.valid & fill_i.fault;	// Walker hit an invalid entry

// ============================================================================
// Read mux and offset decode
// ============================================================================
always_comb begin
	reg_hit = 1'b1;
	rd_data = '0;
	case (apb_i.paddr)
	mmu_cfg_pkg::REG_PTBR:      rd_data = {ptbr_ppn_q, {mmu_cfg_pkg::PAGE_BITS{1'b0}}};
	mmu_cfg_pkg::REG_CTRL:      rd_data = 32'(paging_en_q);
	mmu_cfg_pkg::REG_FAULT_ADR: rd_data = fault_adr_q;
	mmu_cfg_pkg::REG_STATUS:    rd_data = 32'(fault_pend_q);
	default:                    reg_hit = 1'b0;	// Hole in the map
	endcase
end

assign apb_o.pready  = 1'b1;	// Zero wait states
assign apb_o.pslverr = access & (~reg_hit |
	(apb_i.pwrite & (apb_i.paddr == mmu_cfg_pkg::REG_FAULT_ADR)));
assign apb_o.prdata  = rd_data;

// ============================================================================
// Registers
// ============================================================================
always_ff @(posedge clk) begin
	if (rst) begin
		ptbr_ppn_q   <= '0;
		paging_en_q  <= 1'b0;
		fault_pend_q <= 1'b0;
	end else begin
		if (wr_ptbr)
			ptbr_ppn_q <= apb_i.pwdata[mmu_cfg_pkg::PADR_W-1:mmu_cfg_pkg::PAGE_BITS];	// Page aligned
		if (wr_ctrl)
			paging_en_q <= apb_i.pwdata[0];
		if (hw_fault)
			fault_pend_q <= 1'b1;	// New fault beats a same-cycle clear
		else if (sts_clr)
			fault_pend_q <= 1'b0;
	end
end

// Faulting address, captured with the fault
always_ff @(posedge clk) begin
	if (hw_fault)
		fault_adr_q <= fill_i.vadr;
end

assign ctl_o.paging_en = paging_en_q;
assign ctl_o.ptbr_ppn  = ptbr_ppn_q;
assign ctl_o.flush     = wr_ptbr;	// Same edge as the new base
assign irq_o           = fault_pend_q;

endmodule

// ==== hw/tlb_dm.sv ====
module tlb_dm (
	input  logic                       clk,
	input  logic                       rst,
	input  mmu_types_pkg::csr_ctl_t    ctl_i,
	input  mmu_types_pkg::xlat_req_t   req_i,
	input  mmu_types_pkg::tlb_fill_t   fill_i,
	output logic                       ready_o,
	output mmu_types_pkg::xlat_rsp_t   rsp_o,
	output mmu_types_pkg::tlb_miss_t   miss_o
);

localparam int TAG_W = mmu_cfg_pkg::VADR_W - mmu_cfg_pkg::TLB_TAG_LSB;

// Entry storage
logic [mmu_cfg_pkg::TLB_ENTRIES-1:0]  vld_q;
logic [TAG_W-1:0]                     tag_q [mmu_cfg_pkg::TLB_ENTRIES];
logic [mmu_cfg_pkg::PPN_W-1:0]        ppn_q [mmu_cfg_pkg::TLB_ENTRIES];

// Lookup slot
logic                                 req_vld_q;
logic [mmu_cfg_pkg::VADR_W-1:0]       req_vadr_q;
logic                                 busy_q;	// Walk outstanding

// Response built from a fill
logic                                 frsp_vld_q;
logic                                 frsp_fault_q;
logic [mmu_cfg_pkg::PADR_W-1:0]       frsp_padr_q;

logic [mmu_cfg_pkg::TLB_IDX_BITS-1:0] rd_idx;
logic [mmu_cfg_pkg::TLB_IDX_BITS-1:0] wr_idx;
logic                                 hit;
logic                                 miss_now;
logic                                 fill_ok;

assign rd_idx   = req_vadr_q[mmu_cfg_pkg::VPN0_LSB +: mmu_cfg_pkg::TLB_IDX_BITS];
assign wr_idx   = fill_i.vadr[mmu_cfg_pkg::VPN0_LSB +: mmu_cfg_pkg::TLB_IDX_BITS];
assign hit      = vld_q[rd_idx] &
	(tag_q[rd_idx] == req_vadr_q[mmu_cfg_pkg::VADR_W-1:mmu_cfg_pkg::TLB_TAG_LSB]);
assign miss_now = req_vld_q & ctl_i.paging_en & ~hit;
assign fill_ok  = fill_i.valid & ~fill_i.fault;

assign ready_o = ~busy_q & ~miss_now;	// Stall from the miss slot on

// ============================================================================
// Response slot
// ============================================================================
always_comb begin
	if (frsp_vld_q) begin
		rsp_o.valid = 1'b1;
		rsp_o.fault = frsp_fault_q;
		rsp_o.padr  = frsp_padr_q;
	end else begin
		rsp_o.valid = req_vld_q & ~miss_now;
		rsp_o.fault = 1'b0;
		rsp_o.padr  = ctl_i.paging_en ?
			{ppn_q[rd_idx], req_vadr_q[mmu_cfg_pkg::PAGE_BITS-1:0]} : req_vadr_q;	// Bypass
	end
end

assign miss_o.valid = miss_now;
assign miss_o.vadr  = req_vadr_q;

// ============================================================================
// Control state
// ============================================================================
always_ff @(posedge clk) begin
	if (rst) begin
		req_vld_q  <= 1'b0;
		busy_q     <= 1'b0;
		frsp_vld_q <= 1'b0;
		vld_q      <= '0;
	end else begin
		req_vld_q  <= req_i.valid & ready_o;
		frsp_vld_q <= fill_i.valid;	// Answer one cycle after the fill
		if (miss_now)
			busy_q <= 1'b1;
		else if (fill_i.valid)
			busy_q <= 1'b0;
		if (fill_ok)
			vld_q[wr_idx] <= 1'b1;
		if (ctl_i.flush)
			vld_q <= '0;	// Flush wins over a fill
	end
end

// Payload, entries and captured addresses
always_ff @(posedge clk) begin
	if (req_i.valid & ready_o)
		req_vadr_q <= req_i.vadr;
	if (fill_ok) begin
		tag_q[wr_idx] <= fill_i.vadr[mmu_cfg_pkg::VADR_W-1:mmu_cfg_pkg::TLB_TAG_LSB];
		ppn_q[wr_idx] <= fill_i.ppn;
	end
	frsp_fault_q <= fill_i.fault;
	frsp_padr_q  <= fill_i.fault ? '0 :
		{fill_i.ppn, fill_i.vadr[mmu_cfg_pkg::PAGE_BITS-1:0]};
end

endmodule

// ==== hw/ptw_ctrl.sv ====
module ptw_ctrl (
	input  logic                       clk,
	input  logic                       rst,
	input  mmu_types_pkg::csr_ctl_t    ctl_i,
	input  mmu_types_pkg::tlb_miss_t   miss_i,
	input  mmu_types_pkg::mem_rsp_t    mem_rsp_i,
	output mmu_types_pkg::mem_req_t    mem_req_o,
	output mmu_types_pkg::tlb_fill_t   fill_o
);

localparam int VPN_W = mmu_cfg_pkg::VPN1_LSB - mmu_cfg_pkg::VPN0_LSB;	// Bits per level

typedef enum logic [1:0] {
	IDLE,
	L1_READ,	// Level-1 entry in flight
	L0_READ,	// Level-0 entry in flight
	FILL	// Fill pulse to the TLB
} ptw_state_e;

ptw_state_e                      state_q;
logic                            mem_vld_q;
logic [mmu_cfg_pkg::PADR_W-1:0]  mem_adr_q;
logic [mmu_cfg_pkg::VADR_W-1:0]  vadr_q;	// Address being walked
logic                            fill_fault_q;
logic [mmu_cfg_pkg::PPN_W-1:0]   fill_ppn_q;

mmu_types_pkg::pte_u             pte;
logic                            acked;
logic [mmu_cfg_pkg::PADR_W-1:0]  l1_adr;
logic [mmu_cfg_pkg::PADR_W-1:0]  l0_adr;
logic [mmu_cfg_pkg::PPN_W-1:0]   super_ppn;

assign pte   = mem_rsp_i.data;
assign acked = mem_vld_q & mem_rsp_i.ack;

// ============================================================================
// Table addresses
// ============================================================================
// Base page plus vpn1 slot
assign l1_adr = {ctl_i.ptbr_ppn, {mmu_cfg_pkg::PAGE_BITS{1'b0}}} +
	mmu_cfg_pkg::PADR_W'(miss_i.vadr[mmu_cfg_pkg::VADR_W-1:mmu_cfg_pkg::VPN1_LSB]) *
	mmu_cfg_pkg::PADR_W'(mmu_cfg_pkg::PTE_BYTES);

// Pointer view names the level-0 table
assign l0_adr = {pte.ptr.tppn, {mmu_cfg_pkg::PAGE_BITS{1'b0}}} +
	mmu_cfg_pkg::PADR_W'(vadr_q[mmu_cfg_pkg::VPN1_LSB-1:mmu_cfg_pkg::VPN0_LSB]) *
	mmu_cfg_pkg::PADR_W'(mmu_cfg_pkg::PTE_BYTES);

// 4 MB leaf, upper PPN bits from the entry and vpn0 passes through
assign super_ppn = {pte.leaf.ppn[mmu_cfg_pkg::PPN_W-1:VPN_W],
	vadr_q[mmu_cfg_pkg::VPN1_LSB-1:mmu_cfg_pkg::VPN0_LSB]};

// ============================================================================
// Walk FSM
// ============================================================================
always_ff @(posedge clk) begin
	if (rst) begin
		state_q   <= IDLE;
		mem_vld_q <= 1'b0;
	end else begin
		case (state_q)
		IDLE:
			if (miss_i.valid) begin
				mem_vld_q <= 1'b1;	// Level-1 read out at once
				state_q   <= L1_READ;
			end
		L1_READ:
			if (acked) begin
				mem_vld_q <= 1'b0;
				if (!pte.leaf.v || pte.leaf.s)
					state_q <= FILL;	// Fault or superpage ends here
				else
					state_q <= L0_READ;
			end
		L0_READ:
			if (acked) begin
				mem_vld_q <= 1'b0;
				state_q   <= FILL;
			end else if (!mem_vld_q) begin
				mem_vld_q <= 1'b1;	// Issue after the idle gap
			end
		FILL:
			state_q <= IDLE;
		default:
			state_q <= IDLE;
		endcase
	end
end

// Walk payload
always_ff @(posedge clk) begin
	case (state_q)
	IDLE:
		if (miss_i.valid) begin
			vadr_q    <= miss_i.vadr;
			mem_adr_q <= l1_adr;
		end
	L1_READ:
		if (acked) begin
			mem_adr_q    <= l0_adr;	// Unused unless a pointer
			fill_fault_q <= ~pte.leaf.v;
			fill_ppn_q   <= super_ppn;
		end
	L0_READ:
		if (acked) begin
			fill_fault_q <= ~pte.leaf.v;
			fill_ppn_q   <= pte.leaf.ppn;
		end
	default: ;
	endcase
end

assign mem_req_o.valid = mem_vld_q;
assign mem_req_o.adr   = mem_adr_q;

assign fill_o.valid = (state_q == FILL);	// One cycle pulse
assign fill_o.fault = fill_fault_q;
assign fill_o.vadr  = vadr_q;
assign fill_o.ppn   = fill_ppn_q;

endmodule

// ==== hw/mmu_top.sv ====
module mmu_top (
	input  logic                       clk,
	input  logic                       rst,
	input  mmu_types_pkg::apb_req_t    apb_i,
	input  mmu_types_pkg::xlat_req_t   xlat_req_i,
	input  mmu_types_pkg::mem_rsp_t    mem_rsp_i,
	output mmu_types_pkg::apb_rsp_t    apb_o,
	output logic                       xlat_ready_o,
	output mmu_types_pkg::xlat_rsp_t   xlat_rsp_o,
	output mmu_types_pkg::mem_req_t    mem_req_o,
	output logic                       irq_o
);

mmu_types_pkg::csr_ctl_t   csr_ctl;	// Base, enable, flush
mmu_types_pkg::tlb_miss_t  tlb_miss;	// TLB to walker
mmu_types_pkg::tlb_fill_t  tlb_fill;	// Walker to TLB and CSRs

// ============================================================================
// Register block
// ============================================================================
mmu_csr i_csr (
	.clk    (clk),
	.rst    (rst),
	.apb_i  (apb_i),
	.fill_i (tlb_fill),
	.apb_o  (apb_o),
	.ctl_o  (csr_ctl),
	.irq_o  (irq_o)
);

// Lookup, accepts requests and answers them
tlb_dm i_tlb (
	.clk     (clk),
	.rst     (rst),
	.ctl_i   (csr_ctl),
	.req_i   (xlat_req_i),
	.fill_i  (tlb_fill),
	.ready_o (xlat_ready_o),
	.rsp_o   (xlat_rsp_o),
	.miss_o  (tlb_miss)
);

// Table walker, one walk at a time
ptw_ctrl i_ptw (
	.clk       (clk),
	.rst       (rst),
	.ctl_i     (csr_ctl),
	.miss_i    (tlb_miss),
	.mem_rsp_i (mem_rsp_i),
	.mem_req_o (mem_req_o),
	.fill_o    (tlb_fill)
);

endmodule

// ==== verif/mmu_sva.sv ====
module mmu_sva (
	input logic                      clk,
	input logic                      rst,
	input mmu_types_pkg::mem_req_t   mem_req_o,
	input mmu_types_pkg::mem_rsp_t   mem_rsp_i,
	input logic                      xlat_ready_o,
	input mmu_types_pkg::xlat_rsp_t  xlat_rsp_o
);

timeunit 1ns;
timeprecision 1ps;

// ============================================================================
// Memory read port
// ============================================================================
// Request held with the same address until ack
mem_hold_a: assert property (@(posedge clk) disable iff (rst)
	mem_req_o.valid && !mem_rsp_i.ack |=> mem_req_o.valid && $stable(mem_req_o.adr))
	else $error("memory request changed or dropped before ack");

// ============================================================================
// Translation port
// ============================================================================
ready_after_rst_a: assert property (@(posedge clk) $fell(rst) |-> xlat_ready_o)
	else $error("translation port not ready after reset");

// Response stays quiet through reset
no_rsp_in_rst_a: assert property (@(posedge clk) rst |=> !xlat_rsp_o.valid)
	else $error("translation response valid during reset");

endmodule

// ==== verif/mmu_tb.sv ====
module mmu_tb;

timeunit 1ns;
timeprecision 1ps;

localparam int          CLK_PERIOD  = 100;
localparam int          NROWS       = 6;
localparam int          WATCHDOG_NS = (NROWS * 200 + 100) * CLK_PERIOD;
localparam logic [31:0] SEED        = 32'h1db6;
localparam logic [31:0] PT_BASE     = 32'h0001_0000;	// Level-1 table page

typedef struct packed {
	logic        paging;	// CTRL bit 0 for the row
	logic        rewrite;	// PTBR written again first, flushes the TLB
	logic [31:0] vadr;
	logic [31:0] padr;
	logic        fault;
	logic [2:0]  reads;	// Page table reads expected
} row_t;

logic                       clk;
logic                       rst;
mmu_types_pkg::apb_req_t    apb_i;
mmu_types_pkg::xlat_req_t   xlat_req_i;
mmu_types_pkg::mem_rsp_t    mem_rsp_i;
mmu_types_pkg::apb_rsp_t    apb_o;
logic                       xlat_ready_o;
mmu_types_pkg::xlat_rsp_t   xlat_rsp_o;
mmu_types_pkg::mem_req_t    mem_req_o;
logic                       irq_o;

row_t        rows [NROWS];
string       names [NROWS];
logic [31:0] pt_mem [logic [31:0]];	// Sparse page table image
int          read_cnt;	// Acked page table reads
logic        mem_busy;
int          mem_wait;
logic [31:0] rdata;
logic        rerr;
logic [31:0] padr;
logic        fault;
int          reads;

mmu_top i_dut (
	.clk          (clk),
	.rst          (rst),
	.apb_i        (apb_i),
	.xlat_req_i   (xlat_req_i),
	.mem_rsp_i    (mem_rsp_i),
	.apb_o        (apb_o),
	.xlat_ready_o (xlat_ready_o),
	.xlat_rsp_o   (xlat_rsp_o),
	.mem_req_o    (mem_req_o),
	.irq_o        (irq_o)
);

bind mmu_top mmu_sva i_sva (
	.clk          (clk),
	.rst          (rst),
	.mem_req_o    (mem_req_o),
	.mem_rsp_i    (mem_rsp_i),
	.xlat_ready_o (xlat_ready_o),
	.xlat_rsp_o   (xlat_rsp_o)
);

always #(CLK_PERIOD / 2) clk = ~clk;

// ============================================================================
// Memory model, 1 to 4 cycles to ack
// ============================================================================
always @(negedge clk) begin
	mem_rsp_i.ack <= 1'b0;	// Ack lasts one cycle
	if (rst) begin
		mem_busy = 1'b0;
	end else if (mem_req_o.valid && !mem_rsp_i.ack) begin
		if (!mem_busy) begin
			mem_busy = 1'b1;
			mem_wait = 1 + ($urandom % 4);
		end
		mem_wait = mem_wait - 1;
		if (mem_wait == 0) begin
			mem_busy = 1'b0;
			mem_rsp_i.ack  <= 1'b1;
			mem_rsp_i.data <= pt_mem.exists(mem_req_o.adr) ? pt_mem[mem_req_o.adr] : '0;
			read_cnt = read_cnt + 1;
		end
	end
end

function automatic void load_page_table();
	pt_mem[32'h0001_0004] = 32'h8000_0030;	// vpn1 1, pointer to table 0x30
	pt_mem[32'h0003_000C] = 32'h8001_2345;	// vpn0 3, leaf ppn 0x12345
	pt_mem[32'h0001_00C0] = 32'hC00A_BC00;	// vpn1 0x30, superpage
	pt_mem[32'h0001_0008] = 32'h8000_0031;	// vpn1 2, pointer to table 0x31
	pt_mem[32'h0003_1014] = 32'h0007_7777;	// vpn0 5, v clear
endfunction

function automatic void set_row(int idx, string name, logic paging, logic rewrite,
	logic [31:0] vadr, logic [31:0] exp_padr, logic exp_fault, logic [2:0] exp_reads);
	names[idx] = name;
	rows[idx]  = '{paging, rewrite, vadr, exp_padr, exp_fault, exp_reads};
endfunction

task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (exp !== act) begin
		$display("MISMATCH %s %h %h", name, exp, act);
		$display("Simulation failed");
		$fatal(1);
	end
endtask

// ============================================================================
// APB and translation tasks
// ============================================================================
task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
	apb_i = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
	@(negedge clk);
	apb_i.penable = 1'b1;	// Access phase, write lands on next edge
	@(negedge clk);
	apb_i = '0;
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
	apb_i = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
	@(negedge clk);
	apb_i.penable = 1'b1;
	@(negedge clk);
	data  = apb_o.prdata;
	err   = apb_o.pslverr;
	check("pready", 32'd1, 32'(apb_o.pready));	// No wait states
	apb_i = '0;
endtask

task automatic translate(input logic [31:0] vadr, output logic [31:0] rsp_padr,
	output logic rsp_fault, output int rd_count);
	int start;
	while (!xlat_ready_o)
		@(negedge clk);
	start = read_cnt;
	xlat_req_i = '{valid: 1'b1, vadr: vadr};
	@(negedge clk);
	xlat_req_i.valid = 1'b0;
	while (!xlat_rsp_o.valid)	// Pulse visible for a whole cycle
		@(negedge clk);
	rsp_padr  = xlat_rsp_o.padr;
	rsp_fault = xlat_rsp_o.fault;
	rd_count  = read_cnt - start;
endtask

initial begin
	#(WATCHDOG_NS);
	$display("Timeout: the run did not finish in time");
	$display("Simulation failed");
	$fatal(1);
end

// ============================================================================
// Main sequence
// ============================================================================
initial begin
	void'($urandom(SEED));
	clk        = 1'b0;
	rst        = 1'b1;
	apb_i      = '0;
	xlat_req_i = '0;
	mem_rsp_i  = '0;
	read_cnt   = 0;
	mem_busy   = 1'b0;
	mem_wait   = 0;
	load_page_table();
	set_row(0, "bypass",  1'b0, 1'b0, 32'hDEAD_BEEF, 32'hDEAD_BEEF, 1'b0, 3'd0);
	set_row(1, "walk_4k", 1'b1, 1'b0, 32'h0040_3ABC, 32'h1234_5ABC, 1'b0, 3'd2);
	set_row(2, "hit_4k",  1'b1, 1'b0, 32'h0040_3010, 32'h1234_5010, 1'b0, 3'd0);
	// TLB index 7, entry 3 stays valid for the flush row
	set_row(3, "super",   1'b1, 1'b0, 32'h0C12_7456, 32'hABD2_7456, 1'b0, 3'd1);
	set_row(4, "fault",   1'b1, 1'b0, 32'h0080_5008, 32'h0000_0000, 1'b1, 3'd2);
	set_row(5, "flush",   1'b1, 1'b1, 32'h0040_3ABC, 32'h1234_5ABC, 1'b0, 3'd2);
	repeat (4) @(negedge clk);
	rst = 1'b0;
	apb_write(mmu_cfg_pkg::REG_PTBR, PT_BASE);
	for (int i = 0; i < NROWS; i++) begin
		if (rows[i].rewrite)
			apb_write(mmu_cfg_pkg::REG_PTBR, PT_BASE);
		apb_write(mmu_cfg_pkg::REG_CTRL, 32'(rows[i].paging));
		translate(rows[i].vadr, padr, fault, reads);
		check({names[i], " padr"}, rows[i].padr, padr);
		check({names[i], " fault"}, 32'(rows[i].fault), 32'(fault));
		check({names[i], " reads"}, 32'(rows[i].reads), 32'(reads));
	end
	// Fault left pending by the fault row
	check("irq set", 32'd1, 32'(irq_o));
	apb_read(mmu_cfg_pkg::REG_FAULT_ADR, rdata, rerr);
	check("fault_adr", 32'h0080_5008, rdata);
	apb_read(mmu_cfg_pkg::REG_STATUS, rdata, rerr);
	check("status set", 32'd1, rdata);
	apb_write(mmu_cfg_pkg::REG_STATUS, 32'd1);	// W1C
	apb_read(mmu_cfg_pkg::REG_STATUS, rdata, rerr);
	check("status clear", 32'd0, rdata);
	check("irq clear", 32'd0, 32'(irq_o));
	apb_read(8'h10, rdata, rerr);	// Hole in the map
	check("pslverr", 32'd1, 32'(rerr));
	apb_read(mmu_cfg_pkg::REG_PTBR, rdata, rerr);
	check("ptbr readback", PT_BASE, rdata);
	apb_read(mmu_cfg_pkg::REG_CTRL, rdata, rerr);
	check("ctrl readback", 32'd1, rdata);
	$display("Simulation completed successfully");
	$finish;
end

endmodule

// ==== sources.f ====
hw/mmu_cfg_pkg.sv
hw/mmu_types_pkg.sv
hw/mmu_csr.sv
hw/tlb_dm.sv
hw/ptw_ctrl.sv
hw/mmu_top.sv
verif/mmu_sva.sv
verif/mmu_tb.sv
